// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ooo_core
FILELIST := tb.f
OBJ_DIR  := obj_dir

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/ooo_core_checker.sv
`timescale 1ns/1ns

module ooo_core_checker #(
    parameter int NUM_REGS = 16
) (
    input logic                        clk,
    input logic                        rst_n_i,
    input logic                        in_valid_i,
    input logic                        in_ready_i,
    input logic                        iq_full_i,
    input logic                        wb_alu_valid_i,
    input logic [$clog2(NUM_REGS)-1:0] wb_alu_rd_i,
    input logic                        wb_mul_valid_i,
    input logic [$clog2(NUM_REGS)-1:0] wb_mul_rd_i
);

    // nothing retires straight out of reset
    wb_idle_after_reset: assert property (
        @(posedge clk) !rst_n_i |=> (!wb_alu_valid_i && !wb_mul_valid_i)
    ) else $error("writeback valid in the cycle after reset");

    // only one producer per register may be in flight
    wb_distinct_rd: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wb_alu_valid_i && wb_mul_valid_i) |-> (wb_alu_rd_i != wb_mul_rd_i)
    ) else $error("both writeback buses carry the same rd");

    ready_when_free: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (!iq_full_i && !in_valid_i) |-> in_ready_i
    ) else $error("in_ready_o low with a free slot and no valid input");

endmodule

bind ooo_core ooo_core_checker #(
    .NUM_REGS (NUM_REGS)
) u_checker (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .in_valid_i     (in_valid_i),
    .in_ready_i     (in_ready_o),
    .iq_full_i      (iq_full),
    .wb_alu_valid_i (wb_alu_valid_o),
    .wb_alu_rd_i    (wb_alu_rd_o),
    .wb_mul_valid_i (wb_mul_valid_o),
    .wb_mul_rd_i    (wb_mul_rd_o)
);

// File: bench/tb_ooo_core.sv
`timescale 1ns/1ns

module tb_ooo_core import ooo_pkg::*; ();
    localparam int NUM_REGS   = 16;
    localparam int DATA_W     = 32;
    localparam int ID_W       = 8;
    localparam int REG_W      = $clog2(NUM_REGS);
    localparam int MAX_CYCLES = 5000;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    op_e               in_op;
    logic [REG_W-1:0]  in_rd;
    logic [REG_W-1:0]  in_rs1;
    logic [REG_W-1:0]  in_rs2;
    logic [15:0]       in_imm;
    logic [ID_W-1:0]   in_id;
    logic              in_ready;
    logic              wb_alu_valid;
    logic [REG_W-1:0]  wb_alu_rd;
    logic [ID_W-1:0]   wb_alu_id;
    logic [DATA_W-1:0] wb_alu_data;
    logic              wb_mul_valid;
    logic [REG_W-1:0]  wb_mul_rd;
    logic [ID_W-1:0]   wb_mul_id;
    logic [DATA_W-1:0] wb_mul_data;

    // program-order model and bookkeeping per id
    logic [DATA_W-1:0] model_rf [NUM_REGS];
    logic [DATA_W-1:0] exp_data [2**ID_W];
    logic [REG_W-1:0]  exp_rd   [2**ID_W];
    int                wb_seq   [2**ID_W];
    logic [2**ID_W-1:0] pending;
    logic [NUM_REGS-1:0] rd_out;
    logic [ID_W-1:0]   next_id;
    int                pending_cnt;
    int                wb_count;
    int                cycle_cnt;
    int unsigned       seed_val;

    ooo_core #(
        .NUM_REGS   (NUM_REGS),
        .DATA_W     (DATA_W),
        .ID_W       (ID_W),
        .IQ_DEPTH   (4),
        .MUL_STAGES (3)
    ) u_dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .in_valid_i     (in_valid),
        .in_op_i        (in_op),
        .in_rd_i        (in_rd),
        .in_rs1_i       (in_rs1),
        .in_rs2_i       (in_rs2),
        .in_imm_i       (in_imm),
        .in_id_i        (in_id),
        .in_ready_o     (in_ready),
        .wb_alu_valid_o (wb_alu_valid),
        .wb_alu_rd_o    (wb_alu_rd),
        .wb_alu_id_o    (wb_alu_id),
        .wb_alu_data_o  (wb_alu_data),
        .wb_mul_valid_o (wb_mul_valid),
        .wb_mul_rd_o    (wb_mul_rd),
        .wb_mul_id_o    (wb_mul_id),
        .wb_mul_data_o  (wb_mul_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_failed();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string sig, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("Error: %s expected %h, got %h", sig, expected, actual);
        stop_failed();
    endtask

    task automatic report_problem(input string why);
        $display("%s", why);
        stop_failed();
    endtask

    // result of one operation as the ISA defines it
    function automatic logic [31:0] expected_result(op_e op, logic [31:0] a,
                                                    logic [31:0] b, logic [15:0] imm);
        case (op)
            OP_LI:   return {16'h0000, imm};
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_MUL:  return a * b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic record_accept();
        logic [31:0] res;
        res = expected_result(in_op, model_rf[in_rs1], model_rf[in_rs2], in_imm);
        assert (!rd_out[in_rd])
            else report_problem($sformatf("accepted id %0d while r%0d still pending",
                                          in_id, in_rd));
        exp_rd[in_id]   = in_rd;
        exp_data[in_id] = res;
        pending[in_id]  = 1'b1;
        rd_out[in_rd]   = 1'b1;
        model_rf[in_rd] = res;
        pending_cnt     = pending_cnt + 1;
        next_id         = next_id + 1'b1;
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_op(input op_e op, input logic [REG_W-1:0] rd,
                           input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2,
                           input logic [15:0] imm, output logic [ID_W-1:0] id,
                           output int stalls);
        logic accepted;
        accepted = 1'b0;
        stalls   = 0;
        id       = next_id;
        in_valid = 1'b1;
        in_op    = op;
        in_rd    = rd;
        in_rs1   = rs1;
        in_rs2   = rs2;
        in_imm   = imm;
        in_id    = next_id;
        while (!accepted) begin
            #1;
            if (in_ready) begin
                record_accept();
                accepted = 1'b1;
            end else begin
                stalls = stalls + 1;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (pending_cnt != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_writeback(input string bus, input logic [REG_W-1:0] rd,
                                   input logic [ID_W-1:0] id, input logic [31:0] data);
        assert (pending[id])
            else report_problem($sformatf("%s wrote back id %0d, not outstanding", bus, id));
        assert (rd == exp_rd[id])
            else report_value({bus, "_rd_o"}, 32'(exp_rd[id]), 32'(rd));
        assert (data == exp_data[id])
            else report_value({bus, "_data_o"}, exp_data[id], data);
        pending[id] = 1'b0;
        rd_out[rd]  = 1'b0;
        pending_cnt = pending_cnt - 1;
        wb_seq[id]  = wb_count;
        wb_count    = wb_count + 1;
    endtask

    always @(negedge clk) begin
        if (rst_n && wb_alu_valid) begin
            check_writeback("wb_alu", wb_alu_rd, wb_alu_id, wb_alu_data);
        end
        if (rst_n && wb_mul_valid) begin
            check_writeback("wb_mul", wb_mul_rd, wb_mul_id, wb_mul_data);
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            report_problem("timeout, operations still outstanding at the cycle limit");
        end
    end

    initial begin
        logic [ID_W-1:0] id_a;
        logic [ID_W-1:0] id_b;
        int              stalls;
        op_e             op;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_op       = OP_LI;
        in_rd       = '0;
        in_rs1      = '0;
        in_rs2      = '0;
        in_imm      = '0;
        in_id       = '0;
        pending     = '0;
        rd_out      = '0;
        next_id     = '0;
        pending_cnt = 0;
        wb_count    = 0;
        cycle_cnt   = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_rf[r] = '0;
        end
        seed_val = $urandom(32'h74f6);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (in_ready) else report_value("in_ready_o", 32'h1, 32'(in_ready));
        assert (!wb_alu_valid && !wb_mul_valid)
            else report_problem("writeback valid after reset");

        // dependent alu chain
        send_op(OP_LI,  4'd1, 4'd0, 4'd0, 16'h8123, id_a, stalls);
        send_op(OP_ADD, 4'd2, 4'd1, 4'd1, 16'h0000, id_a, stalls);
        send_op(OP_SUB, 4'd3, 4'd2, 4'd1, 16'h0000, id_a, stalls);
        send_op(OP_AND, 4'd4, 4'd3, 4'd2, 16'h0000, id_a, stalls);
        send_op(OP_OR,  4'd5, 4'd4, 4'd1, 16'h0000, id_a, stalls);
        send_op(OP_XOR, 4'd6, 4'd5, 4'd3, 16'h0000, id_a, stalls);
        send_op(OP_SLT, 4'd7, 4'd6, 4'd1, 16'h0000, id_a, stalls);
        send_op(OP_LI,  4'd8, 4'd0, 4'd0, 16'h0123, id_a, stalls);
        send_op(OP_LI,  4'd9, 4'd0, 4'd0, 16'h0456, id_a, stalls);
        wait_idle();

        // younger add overtakes the multiply
        send_op(OP_MUL, 4'd10, 4'd8, 4'd9, 16'h0000, id_a, stalls);
        send_op(OP_ADD, 4'd11, 4'd1, 4'd2, 16'h0000, id_b, stalls);
        wait_idle();
        assert (wb_seq[id_b] < wb_seq[id_a])
            else report_problem("add did not complete before the older multiply");

        // same rd behind a pending multiply must stall
        send_op(OP_MUL, 4'd12, 4'd10, 4'd9, 16'h0000, id_a, stalls);
        send_op(OP_ADD, 4'd12, 4'd1, 4'd1, 16'h0000, id_b, stalls);
        assert (stalls > 0) else report_problem("no dispatch stall on a busy rd");
        wait_idle();

        // random stream on r0..r3, heavy on multiplies
        for (int n = 0; n < 200; n++) begin
            if ($urandom_range(0, 7) == 0) begin
                @(negedge clk);
            end
            if ($urandom_range(0, 1) == 1) begin
                op = OP_MUL;
            end else begin
                op = op_e'(3'($urandom_range(0, 6)));
            end
            send_op(op, 4'($urandom_range(0, 3)), 4'($urandom_range(0, 3)),
                    4'($urandom_range(0, 3)), 16'($urandom()), id_a, stalls);
        end
        wait_idle();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: logic/dispatch_stage.sv
`timescale 1ns/1ns

module dispatch_stage import ooo_pkg::*; #(
    parameter int NUM_REGS = 16,
    parameter int DATA_W   = 32,
    parameter int ID_W     = 8
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        in_valid_i,
    input  op_e                         in_op_i,
    input  logic [$clog2(NUM_REGS)-1:0] in_rd_i,
    input  logic [$clog2(NUM_REGS)-1:0] in_rs1_i,
    input  logic [$clog2(NUM_REGS)-1:0] in_rs2_i,
    input  logic [15:0]                 in_imm_i,
    input  logic [ID_W-1:0]             in_id_i,
    input  logic                        iq_full_i,
    wb_if.snk                           wb_alu,
    wb_if.snk                           wb_mul,
    output logic                        in_ready_o,
    dispatch_if.src                     disp
);
    localparam int REG_W = $clog2(NUM_REGS);

    logic [DATA_W-1:0]     rf [NUM_REGS];
    logic [NUM_REGS-1:0]   busy;
    logic [1:0][REG_W-1:0] rs;
    logic                  rd_pending;
    logic                  accept;

    assign rs[0] = in_rs1_i;
    assign rs[1] = in_rs2_i;

    // rd may be released by a writeback in this same cycle
    assign rd_pending = busy[in_rd_i]
        && !(wb_alu.valid && wb_alu.rd == in_rd_i)
        && !(wb_mul.valid && wb_mul.rd == in_rd_i);

    // waw stall, no renaming
    assign in_ready_o = !iq_full_i && !(in_valid_i && rd_pending);
    assign accept     = in_valid_i && in_ready_o;

    assign disp.valid = accept;
    assign disp.op    = in_op_i;
    assign disp.rd    = in_rd_i;
    assign disp.id    = in_id_i;
    assign disp.imm   = {{(DATA_W-16){1'b0}}, in_imm_i};

    // operand capture: rf first, then writeback bypass, else wait on the register
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            disp.src_val[i]  = rf[rs[i]];
            disp.src_wait[i] = 1'b0;
            disp.src_tag[i]  = rs[i];
            if (in_op_i != OP_LI && busy[rs[i]]) begin
                if (wb_alu.valid && wb_alu.rd == rs[i]) begin
                    disp.src_val[i] = wb_alu.data;
                end else if (wb_mul.valid && wb_mul.rd == rs[i]) begin
                    disp.src_val[i] = wb_mul.data;
                end else begin
                    disp.src_wait[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                rf[r] <= '0;
            end
        end else begin
            if (wb_alu.valid) begin
                rf[wb_alu.rd]   <= wb_alu.data;
                busy[wb_alu.rd] <= 1'b0;
            end
            if (wb_mul.valid) begin
                rf[wb_mul.rd]   <= wb_mul.data;
                busy[wb_mul.rd] <= 1'b0;
            end
            // set wins over a clear of the same rd
            if (accept) begin
                busy[in_rd_i] <= 1'b1;
            end
        end
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage import ooo_pkg::*; #(
    parameter int NUM_REGS   = 16,
    parameter int DATA_W     = 32,
    parameter int ID_W       = 8,
    parameter int MUL_STAGES = 3
) (
    input  logic  clk,
    input  logic  rst_n_i,
    issue_if.snk  iss_alu,
    issue_if.snk  iss_mul,
    wb_if.src     wb_alu,
    wb_if.src     wb_mul
);
    localparam int REG_W = $clog2(NUM_REGS);

    logic [DATA_W-1:0]     alu_res;
    logic [MUL_STAGES-1:0] mul_valid;
    logic [REG_W-1:0]      mul_rd   [MUL_STAGES];
    logic [ID_W-1:0]       mul_id   [MUL_STAGES];
    logic [DATA_W-1:0]     mul_data [MUL_STAGES];

    always_comb begin
        case (iss_alu.op)
            OP_LI:   alu_res = iss_alu.a;
            OP_ADD:  alu_res = iss_alu.a + iss_alu.b;
            OP_SUB:  alu_res = iss_alu.a - iss_alu.b;
            OP_AND:  alu_res = iss_alu.a & iss_alu.b;
            OP_OR:   alu_res = iss_alu.a | iss_alu.b;
            OP_XOR:  alu_res = iss_alu.a ^ iss_alu.b;
            OP_SLT:  alu_res = {{(DATA_W-1){1'b0}}, $signed(iss_alu.a) < $signed(iss_alu.b)};
            default: alu_res = '0;
        endcase
    end

    // alu result register, one cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_alu.valid <= 1'b0;
        end else begin
            wb_alu.valid <= iss_alu.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_alu.rd   <= iss_alu.rd;
        wb_alu.id   <= iss_alu.id;
        wb_alu.data <= alu_res;
    end

    // multiplier pipe, product formed in stage 0
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mul_valid <= '0;
        end else begin
            mul_valid[0] <= iss_mul.valid;
            for (int s = 1; s < MUL_STAGES; s++) begin
                mul_valid[s] <= mul_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        mul_rd[0]   <= iss_mul.rd;
        mul_id[0]   <= iss_mul.id;
        mul_data[0] <= iss_mul.a * iss_mul.b;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_rd[s]   <= mul_rd[s-1];
            mul_id[s]   <= mul_id[s-1];
            mul_data[s] <= mul_data[s-1];
        end
    end

    assign wb_mul.valid = mul_valid[MUL_STAGES-1];
    assign wb_mul.rd    = mul_rd[MUL_STAGES-1];
    assign wb_mul.id    = mul_id[MUL_STAGES-1];
    assign wb_mul.data  = mul_data[MUL_STAGES-1];

endmodule

// File: logic/issue_queue.sv
`timescale 1ns/1ns

module issue_queue import ooo_pkg::*; #(
    parameter int NUM_REGS = 16,
    parameter int DATA_W   = 32,
    parameter int ID_W     = 8,
    parameter int IQ_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n_i,
    dispatch_if.snk  disp,
    wb_if.snk        wb_alu,
    wb_if.snk        wb_mul,
    output logic     iq_full_o,
    issue_if.src     iss_alu,
    issue_if.src     iss_mul
);
    localparam int REG_W = $clog2(NUM_REGS);
    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    logic [IQ_DEPTH-1:0]    slot_valid;
    op_e                    slot_op   [IQ_DEPTH];
    logic [REG_W-1:0]       slot_rd   [IQ_DEPTH];
    logic [ID_W-1:0]        slot_id   [IQ_DEPTH];
    logic [1:0][DATA_W-1:0] slot_val  [IQ_DEPTH];
    logic [1:0]             slot_wait [IQ_DEPTH];
    logic [1:0][REG_W-1:0]  slot_tag  [IQ_DEPTH];

    logic             alu_hit;
    logic             mul_hit;
    logic [IDX_W-1:0] alu_idx;
    logic [IDX_W-1:0] mul_idx;
    logic [IDX_W-1:0] free_idx;

    assign iq_full_o = &slot_valid;

    // scan from the top so the lowest slot wins
    always_comb begin
        alu_hit  = 1'b0;
        mul_hit  = 1'b0;
        alu_idx  = '0;
        mul_idx  = '0;
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (slot_valid[i] && slot_wait[i] == 2'b00) begin
                if (is_mul_op(slot_op[i])) begin
                    mul_hit = 1'b1;
                    mul_idx = IDX_W'(i);
                end else begin
                    alu_hit = 1'b1;
                    alu_idx = IDX_W'(i);
                end
            end
            if (!slot_valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign iss_alu.valid = alu_hit;
    assign iss_alu.op    = slot_op[alu_idx];
    assign iss_alu.rd    = slot_rd[alu_idx];
    assign iss_alu.id    = slot_id[alu_idx];
    assign iss_alu.a     = slot_val[alu_idx][0];
    assign iss_alu.b     = slot_val[alu_idx][1];

    assign iss_mul.valid = mul_hit;
    assign iss_mul.op    = slot_op[mul_idx];
    assign iss_mul.rd    = slot_rd[mul_idx];
    assign iss_mul.id    = slot_id[mul_idx];
    assign iss_mul.a     = slot_val[mul_idx][0];
    assign iss_mul.b     = slot_val[mul_idx][1];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            slot_valid <= '0;
        end else begin
            if (alu_hit) begin
                slot_valid[alu_idx] <= 1'b0;
            end
            if (mul_hit) begin
                slot_valid[mul_idx] <= 1'b0;
            end
            if (disp.valid) begin
                slot_valid[free_idx] <= 1'b1;
            end
        end
    end

    // wakeup on writeback, then fill of the free slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            for (int j = 0; j < 2; j++) begin
                if (slot_valid[i] && slot_wait[i][j]) begin
                    if (wb_alu.valid && wb_alu.rd == slot_tag[i][j]) begin
                        slot_val[i][j]  <= wb_alu.data;
                        slot_wait[i][j] <= 1'b0;
                    end else if (wb_mul.valid && wb_mul.rd == slot_tag[i][j]) begin
                        slot_val[i][j]  <= wb_mul.data;
                        slot_wait[i][j] <= 1'b0;
                    end
                end
            end
        end
        if (disp.valid) begin
            slot_op[free_idx]     <= disp.op;
            slot_rd[free_idx]     <= disp.rd;
            slot_id[free_idx]     <= disp.id;
            // li carries its immediate as operand a
            slot_val[free_idx][0] <= (disp.op == OP_LI) ? disp.imm : disp.src_val[0];
            slot_val[free_idx][1] <= disp.src_val[1];
            slot_wait[free_idx]   <= disp.src_wait;
            slot_tag[free_idx]    <= disp.src_tag;
        end
    end

endmodule

// File: logic/ooo_core.sv
`timescale 1ns/1ns

module ooo_core import ooo_pkg::*; #(
    parameter int NUM_REGS   = 16,
    parameter int DATA_W     = 32,
    parameter int ID_W       = 8,
    parameter int IQ_DEPTH   = 4,
    parameter int MUL_STAGES = 3
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        in_valid_i,
    input  op_e                         in_op_i,
    input  logic [$clog2(NUM_REGS)-1:0] in_rd_i,
    input  logic [$clog2(NUM_REGS)-1:0] in_rs1_i,
    input  logic [$clog2(NUM_REGS)-1:0] in_rs2_i,
    input  logic [15:0]                 in_imm_i,
    input  logic [ID_W-1:0]             in_id_i,
    output logic                        in_ready_o,
    output logic                        wb_alu_valid_o,
    output logic [$clog2(NUM_REGS)-1:0] wb_alu_rd_o,
    output logic [ID_W-1:0]             wb_alu_id_o,
    output logic [DATA_W-1:0]           wb_alu_data_o,
    output logic                        wb_mul_valid_o,
    output logic [$clog2(NUM_REGS)-1:0] wb_mul_rd_o,
    output logic [ID_W-1:0]             wb_mul_id_o,
    output logic [DATA_W-1:0]           wb_mul_data_o
);
    logic iq_full;

    dispatch_if #(.NUM_REGS(NUM_REGS), .DATA_W(DATA_W), .ID_W(ID_W)) disp_bus ();
    issue_if    #(.NUM_REGS(NUM_REGS), .DATA_W(DATA_W), .ID_W(ID_W)) iss_alu ();
    issue_if    #(.NUM_REGS(NUM_REGS), .DATA_W(DATA_W), .ID_W(ID_W)) iss_mul ();
    wb_if       #(.NUM_REGS(NUM_REGS), .DATA_W(DATA_W), .ID_W(ID_W)) wb_alu ();
    wb_if       #(.NUM_REGS(NUM_REGS), .DATA_W(DATA_W), .ID_W(ID_W)) wb_mul ();

    dispatch_stage #(
        .NUM_REGS (NUM_REGS),
        .DATA_W   (DATA_W),
        .ID_W     (ID_W)
    ) u_dispatch (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_valid_i (in_valid_i),
        .in_op_i    (in_op_i),
        .in_rd_i    (in_rd_i),
        .in_rs1_i   (in_rs1_i),
        .in_rs2_i   (in_rs2_i),
        .in_imm_i   (in_imm_i),
        .in_id_i    (in_id_i),
        .iq_full_i  (iq_full),
        .wb_alu     (wb_alu),
        .wb_mul     (wb_mul),
        .in_ready_o (in_ready_o),
        .disp       (disp_bus)
    );

    issue_queue #(
        .NUM_REGS (NUM_REGS),
        .DATA_W   (DATA_W),
        .ID_W     (ID_W),
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .disp      (disp_bus),
        .wb_alu    (wb_alu),
        .wb_mul    (wb_mul),
        .iq_full_o (iq_full),
        .iss_alu   (iss_alu),
        .iss_mul   (iss_mul)
    );

    execute_stage #(
        .NUM_REGS   (NUM_REGS),
        .DATA_W     (DATA_W),
        .ID_W       (ID_W),
        .MUL_STAGES (MUL_STAGES)
    ) u_exec (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .iss_alu (iss_alu),
        .iss_mul (iss_mul),
        .wb_alu  (wb_alu),
        .wb_mul  (wb_mul)
    );

    assign wb_alu_valid_o = wb_alu.valid;
    assign wb_alu_rd_o    = wb_alu.rd;
    assign wb_alu_id_o    = wb_alu.id;
    assign wb_alu_data_o  = wb_alu.data;
    assign wb_mul_valid_o = wb_mul.valid;
    assign wb_mul_rd_o    = wb_mul.rd;
    assign wb_mul_id_o    = wb_mul.id;
    assign wb_mul_data_o  = wb_mul.data;

endmodule

// File: logic/ooo_ifs.sv
`timescale 1ns/1ns

interface dispatch_if import ooo_pkg::*; #(
    parameter int NUM_REGS = 16,
    parameter int DATA_W   = 32,
    parameter int ID_W     = 8
);
    localparam int REG_W = $clog2(NUM_REGS);

    logic                  valid;
    op_e                   op;
    logic [REG_W-1:0]      rd;
    logic [ID_W-1:0]       id;
    logic [DATA_W-1:0]     imm;
    // index 0 is rs1, index 1 is rs2
    logic [1:0][DATA_W-1:0] src_val;
    logic [1:0]             src_wait;
    logic [1:0][REG_W-1:0]  src_tag;

    modport src (output valid, op, rd, id, imm, src_val, src_wait, src_tag);
    modport snk (input  valid, op, rd, id, imm, src_val, src_wait, src_tag);
endinterface

interface issue_if import ooo_pkg::*; #(
    parameter int NUM_REGS = 16,
    parameter int DATA_W   = 32,
    parameter int ID_W     = 8
);
    logic                        valid;
    op_e                         op;
    logic [$clog2(NUM_REGS)-1:0] rd;
    logic [ID_W-1:0]             id;
    logic [DATA_W-1:0]           a;
    logic [DATA_W-1:0]           b;

    modport src (output valid, op, rd, id, a, b);
    modport snk (input  valid, op, rd, id, a, b);
endinterface

interface wb_if #(
    parameter int NUM_REGS = 16,
    parameter int DATA_W   = 32,
    parameter int ID_W     = 8
);
    logic                        valid;
    logic [$clog2(NUM_REGS)-1:0] rd;
    logic [ID_W-1:0]             id;
    logic [DATA_W-1:0]           data;

    modport src (output valid, rd, id, data);
    modport snk (input  valid, rd, id, data);
endinterface

// File: logic/ooo_pkg.sv
package ooo_pkg;

    // integer operations handled by the engine
    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_SLT = 3'd6,
        OP_MUL = 3'd7
    } op_e;

    // routes an operation to the multiplier
    function automatic logic is_mul_op(op_e op);
        return op == OP_MUL;
    endfunction

endpackage

// File: tb.f
logic/ooo_pkg.sv
logic/ooo_ifs.sv
logic/dispatch_stage.sv
logic/issue_queue.sv
logic/execute_stage.sv
logic/ooo_core.sv
bench/ooo_core_checker.sv
bench/tb_ooo_core.sv
